// ==== project.f ====
source/rv_slice_pkg.sv
source/immediate.sv
source/instr_decode.sv
source/int_execute.sv
source/regfile_commit.sv
source/exec_slice_top.sv
test/tb_exec_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
# Success is decided by the pass message in the simulator output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_exec_slice -o tb_exec_slice \
    && ./obj_dir/tb_exec_slice | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: test passed" \
    || { echo "run_sim: test failed"; exit 1; }

// ==== source/exec_slice_top.sv ====
/* Top of the execution slice, XLEN follows the 64-bit port type
   Redirects are only reported, fetch belongs to the surrounding core */
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  rv_slice_pkg::instr_t    instr_i,
    input  rv_slice_pkg::bus64_t    pc_i,
    output logic                    commit_valid_o,
    input  logic                    commit_ready_i,
    output rv_slice_pkg::bus64_t    commit_pc_o,
    output rv_slice_pkg::reg_addr_t commit_rd_o,
    output logic                    commit_we_o,
    output rv_slice_pkg::bus64_t    commit_data_o,
    output logic                    commit_redirect_o,
    output rv_slice_pkg::bus64_t    commit_target_o,
    output logic                    commit_illegal_o
);
    import rv_slice_pkg::*;

    localparam int unsigned XLEN = $bits(bus64_t);

    // Register read
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    // Decode to execute
    logic            dec_valid;
    logic            dec_ready;
    logic [XLEN-1:0] dec_pc;
    logic [XLEN-1:0] dec_op_a;
    logic [XLEN-1:0] dec_op_b;
    logic [XLEN-1:0] dec_imm;
    alu_op_e         dec_alu_op;
    branch_cond_e    dec_branch;
    logic            dec_use_imm;
    logic            dec_word;
    reg_addr_t       dec_rd;
    logic            dec_we;
    logic            dec_is_jump;
    logic            dec_is_jalr;
    logic            dec_illegal;
    // Execute to result
    logic            ex_valid;
    logic            ex_ready;
    logic [XLEN-1:0] ex_pc;
    reg_addr_t       ex_rd;
    logic            ex_we;
    logic [XLEN-1:0] ex_data;
    logic            ex_redirect;
    logic [XLEN-1:0] ex_target;
    logic            ex_illegal;

    instr_decode #(.XLEN(XLEN)) instr_decode_i (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .instr_valid_i (instr_valid_i), .instr_ready_o (instr_ready_o),
        .instr_i (instr_i), .pc_i (pc_i),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .dec_valid_o (dec_valid), .dec_ready_i (dec_ready), .dec_pc_o (dec_pc),
        .dec_op_a_o (dec_op_a), .dec_op_b_o (dec_op_b), .dec_imm_o (dec_imm),
        .dec_alu_op_o (dec_alu_op), .dec_branch_o (dec_branch),
        .dec_use_imm_o (dec_use_imm), .dec_word_o (dec_word),
        .dec_rd_o (dec_rd), .dec_we_o (dec_we), .dec_is_jump_o (dec_is_jump),
        .dec_is_jalr_o (dec_is_jalr), .dec_illegal_o (dec_illegal),
        .ex_rd_i (ex_rd), .ex_we_i (ex_we), .ex_valid_i (ex_valid)
    );

    int_execute #(.XLEN(XLEN)) int_execute_i (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .dec_valid_i (dec_valid), .dec_ready_o (dec_ready), .dec_pc_i (dec_pc),
        .dec_op_a_i (dec_op_a), .dec_op_b_i (dec_op_b), .dec_imm_i (dec_imm),
        .dec_alu_op_i (dec_alu_op), .dec_branch_i (dec_branch),
        .dec_use_imm_i (dec_use_imm), .dec_word_i (dec_word),
        .dec_rd_i (dec_rd), .dec_we_i (dec_we), .dec_is_jump_i (dec_is_jump),
        .dec_is_jalr_i (dec_is_jalr), .dec_illegal_i (dec_illegal),
        .ex_valid_o (ex_valid), .ex_ready_i (ex_ready), .ex_pc_o (ex_pc),
        .ex_rd_o (ex_rd), .ex_we_o (ex_we), .ex_data_o (ex_data),
        .ex_redirect_o (ex_redirect), .ex_target_o (ex_target),
        .ex_illegal_o (ex_illegal)
    );

    regfile_commit #(.XLEN(XLEN)) regfile_commit_i (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
        .ex_valid_i (ex_valid), .ex_ready_o (ex_ready), .ex_pc_i (ex_pc),
        .ex_rd_i (ex_rd), .ex_we_i (ex_we), .ex_data_i (ex_data),
        .ex_redirect_i (ex_redirect), .ex_target_i (ex_target),
        .ex_illegal_i (ex_illegal),
        .commit_valid_o (commit_valid_o), .commit_ready_i (commit_ready_i),
        .commit_pc_o (commit_pc_o), .commit_rd_o (commit_rd_o),
        .commit_we_o (commit_we_o), .commit_data_o (commit_data_o),
        .commit_redirect_o (commit_redirect_o), .commit_target_o (commit_target_o),
        .commit_illegal_o (commit_illegal_o)
    );

endmodule

`default_nettype wire

// ==== source/immediate.sv ====
/* Immediate generator for the I, B, U and J formats only
   Store and CSR immediates are not produced, unknown opcodes give zero */
`timescale 1ns/1ps
`default_nettype none

module immediate #(
    parameter int unsigned XLEN = 64
) (
    input  rv_slice_pkg::instr_t instr_i,
    output logic [XLEN-1:0]      imm_o
);
    import rv_slice_pkg::*;

    logic [31:0] imm_i_type;
    logic [31:0] imm_b_type;
    logic [31:0] imm_u_type;
    logic [31:0] imm_j_type;
    logic [31:0] imm_sel;

    // Each format is assembled to 32 bits with bit 31 as sign
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    // J format scatters imm[20:1] over the upper 20 bits
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode_e'(instr_i[6:0]))
            OP_LUI, OP_AUIPC: imm_sel = imm_u_type;
            OP_JAL:           imm_sel = imm_j_type;
            OP_BRANCH:        imm_sel = imm_b_type;
            // Word forms share the I format
            OP_JALR, OP_ALU_I, OP_ALU_I_W: begin
                imm_sel = imm_i_type;
            end
            default:          imm_sel = '0;
        endcase
    end

    // Sign extension from bit 31 up to XLEN
    assign imm_o = XLEN'($signed(imm_sel));

endmodule

`default_nettype wire

// ==== source/instr_decode.sv ====
/* Decode stage with register read and one pipeline register. There is no forwarding,
   so instr_ready_o stays low on a read-after-write hazard until the producer commits */
`timescale 1ns/1ps
`default_nettype none

module instr_decode #(
    parameter int unsigned XLEN = 64
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       instr_valid_i,
    output logic                       instr_ready_o,
    input  rv_slice_pkg::instr_t       instr_i,
    input  logic [XLEN-1:0]            pc_i,
    output rv_slice_pkg::reg_addr_t    rs1_addr_o,
    output rv_slice_pkg::reg_addr_t    rs2_addr_o,
    input  logic [XLEN-1:0]            rs1_data_i,
    input  logic [XLEN-1:0]            rs2_data_i,
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output logic [XLEN-1:0]            dec_pc_o,
    output logic [XLEN-1:0]            dec_op_a_o,
    output logic [XLEN-1:0]            dec_op_b_o,
    output logic [XLEN-1:0]            dec_imm_o,
    output rv_slice_pkg::alu_op_e      dec_alu_op_o,
    output rv_slice_pkg::branch_cond_e dec_branch_o,
    output logic                       dec_use_imm_o,
    output logic                       dec_word_o,
    output rv_slice_pkg::reg_addr_t    dec_rd_o,
    output logic                       dec_we_o,
    output logic                       dec_is_jump_o,
    output logic                       dec_is_jalr_o,
    output logic                       dec_illegal_o,
    input  rv_slice_pkg::reg_addr_t    ex_rd_i,
    input  logic                       ex_we_i,
    input  logic                       ex_valid_i
);
    import rv_slice_pkg::*;

    opcode_e         opcode;
    logic [2:0]      f3;
    logic [6:0]      f7;
    reg_addr_t       rd;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op_a;
    alu_op_e         alu_op;
    branch_cond_e    branch;
    logic            use_imm;
    logic            word;
    logic            we;
    logic            is_jump;
    logic            is_jalr;
    logic            illegal;
    logic            reg_form;
    logic            f7_ok;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            hazard;

    assign opcode     = opcode_e'(instr_i[6:0]);
    assign f3         = instr_i[14:12];
    assign f7         = instr_i[31:25];
    assign rd         = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    immediate #(.XLEN(XLEN)) immediate_i (
        .instr_i (instr_i),
        .imm_o   (imm)
    );

    always_comb begin
        alu_op   = ALU_ADD;
        branch   = BR_NONE;
        use_imm  = 1'b0;
        word     = 1'b0;
        we       = 1'b0;
        is_jump  = 1'b0;
        is_jalr  = 1'b0;
        illegal  = 1'b0;
        reg_form = 1'b0;
        f7_ok    = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        op_a     = rs1_data_i;
        case (opcode)
            OP_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                we      = 1'b1;
            end
            OP_AUIPC: begin
                // pc replaces rs1 so that execute only adds
                op_a    = pc_i;
                use_imm = 1'b1;
                we      = 1'b1;
            end
            OP_JAL: begin
                alu_op  = ALU_LINK;
                is_jump = 1'b1;
                we      = 1'b1;
            end
            OP_JALR: begin
                alu_op   = ALU_LINK;
                is_jump  = 1'b1;
                is_jalr  = 1'b1;
                we       = 1'b1;
                uses_rs1 = 1'b1;
                illegal  = (f3 != F3_JALR);
            end
            OP_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (f3)
                    F3_BEQ:  branch = BR_BEQ;
                    F3_BNE:  branch = BR_BNE;
                    F3_BLT:  branch = BR_BLT;
                    F3_BGE:  branch = BR_BGE;
                    F3_BLTU: branch = BR_BLTU;
                    F3_BGEU: branch = BR_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_ALU_I, OP_ALU_R, OP_ALU_I_W, OP_ALU_R_W: begin
                reg_form = (opcode == OP_ALU_R) || (opcode == OP_ALU_R_W);
                word     = (opcode == OP_ALU_I_W) || (opcode == OP_ALU_R_W);
                use_imm  = !reg_form;
                uses_rs1 = 1'b1;
                uses_rs2 = reg_form;
                we       = 1'b1;
                // Bit 30 picks SUB and SRA
                case (f3)
                    F3_ADD_SUB: alu_op = (reg_form && f7[5]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = f7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                endcase
                if (reg_form) begin
                    f7_ok = (f7 == 7'b0) || ((f7 == 7'b0100000)
                            && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                end else if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                    // Shift immediates, bit 25 is shamt[5] and only legal at 64 bits
                    f7_ok = (f7[6:1] == {1'b0, f7[5] && (f3 == F3_SRL_SRA), 4'b0})
                            && !(f7[0] && (word || XLEN == 32));
                end
                // Word forms exist only for add, sub and shifts, and only at 64 bits
                illegal = !f7_ok || (word && (XLEN == 32 || !(f3 == F3_ADD_SUB
                          || f3 == F3_SLL || f3 == F3_SRL_SRA)));
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            we      = 1'b0;
            is_jump = 1'b0;
        end
        // x0 destinations never write
        if (rd == '0) begin
            we = 1'b0;
        end
    end

    // Read-after-write against the decode and the execute register
    assign hazard = (uses_rs1 && ((dec_valid_o && dec_we_o && dec_rd_o == rs1_addr_o)
                    || (ex_valid_i && ex_we_i && ex_rd_i == rs1_addr_o)))
                 || (uses_rs2 && ((dec_valid_o && dec_we_o && dec_rd_o == rs2_addr_o)
                    || (ex_valid_i && ex_we_i && ex_rd_i == rs2_addr_o)));

    assign instr_ready_o = (!dec_valid_o || dec_ready_i) && !hazard;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (!dec_valid_o || dec_ready_i) begin
            dec_valid_o <= instr_valid_i && !hazard;
        end
    end

    // Payload loads only on an accepted instruction
    always_ff @(posedge clk_i) begin
        if (instr_valid_i && instr_ready_o) begin
            dec_pc_o      <= pc_i;
            dec_op_a_o    <= op_a;
            dec_op_b_o    <= rs2_data_i;
            dec_imm_o     <= imm;
            dec_alu_op_o  <= alu_op;
            dec_branch_o  <= branch;
            dec_use_imm_o <= use_imm;
            dec_word_o    <= word;
            dec_rd_o      <= rd;
            dec_we_o      <= we;
            dec_is_jump_o <= is_jump;
            dec_is_jalr_o <= is_jalr;
            dec_illegal_o <= illegal;
        end
    end

    // A stalled instruction stays on the input until it is taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable(instr_i)
            && $stable(pc_i));

endmodule

`default_nettype wire

// ==== source/int_execute.sv ====
/* Execute stage with ALU, branch compare and target adder
   Word forms assume XLEN of 64, decode marks them illegal otherwise */
`timescale 1ns/1ps
`default_nettype none

module int_execute #(
    parameter int unsigned XLEN = 64
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       dec_valid_i,
    output logic                       dec_ready_o,
    input  logic [XLEN-1:0]            dec_pc_i,
    input  logic [XLEN-1:0]            dec_op_a_i,
    input  logic [XLEN-1:0]            dec_op_b_i,
    input  logic [XLEN-1:0]            dec_imm_i,
    input  rv_slice_pkg::alu_op_e      dec_alu_op_i,
    input  rv_slice_pkg::branch_cond_e dec_branch_i,
    input  logic                       dec_use_imm_i,
    input  logic                       dec_word_i,
    input  rv_slice_pkg::reg_addr_t    dec_rd_i,
    input  logic                       dec_we_i,
    input  logic                       dec_is_jump_i,
    input  logic                       dec_is_jalr_i,
    input  logic                       dec_illegal_i,
    output logic                       ex_valid_o,
    input  logic                       ex_ready_i,
    output logic [XLEN-1:0]            ex_pc_o,
    output rv_slice_pkg::reg_addr_t    ex_rd_o,
    output logic                       ex_we_o,
    output logic [XLEN-1:0]            ex_data_o,
    output logic                       ex_redirect_o,
    output logic [XLEN-1:0]            ex_target_o,
    output logic                       ex_illegal_o
);
    import rv_slice_pkg::*;

    localparam int unsigned SHW = $clog2(XLEN);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sh_a;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] alu_full;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] tgt_sum;
    logic            taken;

    assign op_b = dec_use_imm_i ? dec_imm_i : dec_op_b_i;

    // Word shifts take five shamt bits and a 32-bit source
    assign shamt = dec_word_i ? SHW'(op_b[4:0]) : op_b[SHW-1:0];
    assign sh_a  = !dec_word_i ? dec_op_a_i
                 : (dec_alu_op_i == ALU_SRA) ? XLEN'($signed(dec_op_a_i[31:0]))
                 : XLEN'(dec_op_a_i[31:0]);

    always_comb begin
        case (dec_alu_op_i)
            ALU_ADD:    alu_full = dec_op_a_i + op_b;
            ALU_SUB:    alu_full = dec_op_a_i - op_b;
            ALU_SLL:    alu_full = sh_a << shamt;
            ALU_SLT:    alu_full = XLEN'($signed(dec_op_a_i) < $signed(op_b));
            ALU_SLTU:   alu_full = XLEN'(dec_op_a_i < op_b);
            ALU_XOR:    alu_full = dec_op_a_i ^ op_b;
            ALU_SRL:    alu_full = sh_a >> shamt;
            ALU_SRA:    alu_full = $signed(sh_a) >>> shamt;
            ALU_OR:     alu_full = dec_op_a_i | op_b;
            ALU_AND:    alu_full = dec_op_a_i & op_b;
            ALU_PASS_B: alu_full = op_b;
            ALU_LINK:   alu_full = dec_pc_i + XLEN'(4);
            default:    alu_full = '0;
        endcase
    end

    // Word results are the low half, sign extended
    assign result = dec_word_i ? XLEN'($signed(alu_full[31:0])) : alu_full;

    // Branch compare always uses the two registers
    always_comb begin
        case (dec_branch_i)
            BR_BEQ:  taken = (dec_op_a_i == dec_op_b_i);
            BR_BNE:  taken = (dec_op_a_i != dec_op_b_i);
            BR_BLT:  taken = ($signed(dec_op_a_i) < $signed(dec_op_b_i));
            BR_BGE:  taken = ($signed(dec_op_a_i) >= $signed(dec_op_b_i));
            BR_BLTU: taken = (dec_op_a_i < dec_op_b_i);
            BR_BGEU: taken = (dec_op_a_i >= dec_op_b_i);
            default: taken = 1'b0;
        endcase
    end

    // JALR is relative to rs1, branches and JAL to pc
    assign tgt_sum = (dec_is_jalr_i ? dec_op_a_i : dec_pc_i) + dec_imm_i;

    assign dec_ready_o = !ex_valid_o || ex_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i && dec_ready_o) begin
            ex_pc_o       <= dec_pc_i;
            ex_rd_o       <= dec_rd_i;
            ex_we_o       <= dec_we_i;
            ex_data_o     <= result;
            ex_redirect_o <= dec_is_jump_i || taken;
            // Bit 0 cleared for JALR only
            ex_target_o   <= {tgt_sum[XLEN-1:1], tgt_sum[0] && !dec_is_jalr_i};
            ex_illegal_o  <= dec_illegal_i;
        end
    end

    // Decode must never let an illegal encoding write
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_valid_o |-> !(ex_we_o && ex_illegal_o));

endmodule

`default_nettype wire

// ==== source/regfile_commit.sv ====
/* Register file and commit port, x0 reads as zero
   Writes land on the commit transfer edge, so reads see them one cycle later */
`timescale 1ns/1ps
`default_nettype none

module regfile_commit #(
    parameter int unsigned XLEN = 64
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  rv_slice_pkg::reg_addr_t rs1_addr_i,
    input  rv_slice_pkg::reg_addr_t rs2_addr_i,
    output logic [XLEN-1:0]         rs1_data_o,
    output logic [XLEN-1:0]         rs2_data_o,
    input  logic                    ex_valid_i,
    output logic                    ex_ready_o,
    input  logic [XLEN-1:0]         ex_pc_i,
    input  rv_slice_pkg::reg_addr_t ex_rd_i,
    input  logic                    ex_we_i,
    input  logic [XLEN-1:0]         ex_data_i,
    input  logic                    ex_redirect_i,
    input  logic [XLEN-1:0]         ex_target_i,
    input  logic                    ex_illegal_i,
    output logic                    commit_valid_o,
    input  logic                    commit_ready_i,
    output logic [XLEN-1:0]         commit_pc_o,
    output rv_slice_pkg::reg_addr_t commit_rd_o,
    output logic                    commit_we_o,
    output logic [XLEN-1:0]         commit_data_o,
    output logic                    commit_redirect_o,
    output logic [XLEN-1:0]         commit_target_o,
    output logic                    commit_illegal_o
);
    // Only x1 to x31 have storage
    logic [XLEN-1:0] regs_q [1:31];
    logic            wr_en;

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // Execute register drives the commit port directly
    assign commit_valid_o    = ex_valid_i;
    assign ex_ready_o        = commit_ready_i;
    assign commit_pc_o       = ex_pc_i;
    assign commit_rd_o       = ex_rd_i;
    assign commit_we_o       = ex_we_i;
    assign commit_data_o     = ex_data_i;
    assign commit_redirect_o = ex_redirect_i;
    assign commit_target_o   = ex_target_i;
    assign commit_illegal_o  = ex_illegal_i;

    assign wr_en = commit_valid_o && commit_ready_i && commit_we_o && (commit_rd_o != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[commit_rd_o] <= commit_data_o;
        end
    end

    // Decode already drops the write enable for x0
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_valid_o && commit_we_o |-> commit_rd_o != '0);

endmodule

`default_nettype wire

// ==== source/rv_slice_pkg.sv ====
/* Types and encodings shared by the RV64I execution slice
   Only the opcodes and function codes that the slice executes are listed */
`default_nettype none

package rv_slice_pkg;

    // Data word, instruction word and register index
    typedef logic [63:0] bus64_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes in bits 6 to 0
    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU_R   = 7'b0110011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU_R_W = 7'b0111011
    } opcode_e;

    // Execute operations, LINK gives pc plus 4
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_PASS_B, ALU_LINK
    } alu_op_e;

    // Branch conditions, NONE for everything that is not a branch
    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_cond_e;

    // Function-3 of the ALU groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Function-3 of BRANCH and JALR
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;

endpackage

`default_nettype wire

// ==== test/exec_slice_vectors.txt ====
// Columns (hex): instr pc rd we data redirect target illegal
// rd and data only count when we is 1, target only when redirect is 1
123450B7 1000 01 1 0000000012345000 0 0 0
FFFFF137 1004 02 1 FFFFFFFFFFFFF000 0 0 0
80000197 1008 03 1 FFFFFFFF80001008 0 0 0
FFF08213 100C 04 1 0000000012344FFF 0 0 0
002082B3 1010 05 1 0000000012344000 0 0 0
40110333 1014 06 1 FFFFFFFFEDCBA000 0 0 0
404153B3 1018 07 1 FFFFFFFFFFFFFFFF 0 0 0
00415433 101C 08 1 0000000000000001 0 0 0
0030949B 1020 09 1 FFFFFFFF91A28000 0 0 0
4010053B 1024 0A 1 FFFFFFFFEDCBB000 0 0 0
4044D59B 1028 0B 1 FFFFFFFFF91A2800 0 0 0
FFF12613 102C 0C 1 0000000000000001 0 0 0
0020B6B3 1030 0D 1 0000000000000001 0 0 0
FFF0C713 1034 0E 1 FFFFFFFFEDCBAFFF 0 0 0
00108863 1038 00 0 0000000000000000 1 1048 0
FE114CE3 103C 00 0 0000000000000000 1 1034 0
0020F863 1040 00 0 0000000000000000 0 0 0
801FF7EF 1044 0F 1 0000000000001048 1 0844 0
00378867 1048 10 1 000000000000104C 1 104A 0
00508013 104C 00 0 0000000000000000 0 0 0
ABCDE037 1050 00 0 0000000000000000 0 0 0
00700893 1054 11 1 0000000000000007 0 0 0
0000B903 1058 00 0 0000000000000000 0 0 1
00E889B3 105C 13 1 FFFFFFFFEDCBB006 0 0 0
00090A33 1060 14 1 0000000000000000 0 0 0
00198A93 1064 15 1 FFFFFFFFEDCBB007 0 0 0
004AFB33 1068 16 1 0000000000000007 0 0 0

// ==== test/tb_exec_slice.sv ====
/* Testbench for exec_slice_top, reads test/exec_slice_vectors.txt from the project root
   Expected values assume a register file of zeros after reset and in-order commits */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_slice;

    localparam int          NUM_VEC    = 27;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] LFSR_SEED  = 32'h74eb_17fe;

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic        instr_ready_o;
    logic [31:0] instr_i;
    logic [63:0] pc_i;
    logic        commit_valid_o;
    logic        commit_ready_i;
    logic [63:0] commit_pc_o;
    logic [4:0]  commit_rd_o;
    logic        commit_we_o;
    logic [63:0] commit_data_o;
    logic        commit_redirect_o;
    logic [63:0] commit_target_o;
    logic        commit_illegal_o;

    // Eight words per vector: instr pc rd we data redirect target illegal
    logic [63:0] vec_mem [0:NUM_VEC*8-1];
    int          accepted_q [$];
    logic [31:0] lfsr_q;
    int          errors;
    int          timeouts;
    logic        vectors_ok;

    exec_slice_top dut_i (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .instr_valid_i (instr_valid_i), .instr_ready_o (instr_ready_o),
        .instr_i (instr_i), .pc_i (pc_i),
        .commit_valid_o (commit_valid_o), .commit_ready_i (commit_ready_i),
        .commit_pc_o (commit_pc_o), .commit_rd_o (commit_rd_o),
        .commit_we_o (commit_we_o), .commit_data_o (commit_data_o),
        .commit_redirect_o (commit_redirect_o), .commit_target_o (commit_target_o),
        .commit_illegal_o (commit_illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One step per bit
    task automatic draw_bit(output logic bit_o);
        bit_o  = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    task automatic compare_field(input string name, input int idx,
                                 input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t: vector %0d %s is %h, expected %h", $time, idx, name, got, exp);
        end
    endtask

    task automatic check_commit(input int idx);
        int base;
        base = 8 * idx;
        compare_field("pc", idx, commit_pc_o, vec_mem[base+1]);
        compare_field("we", idx, 64'(commit_we_o), vec_mem[base+3]);
        compare_field("redirect", idx, 64'(commit_redirect_o), vec_mem[base+5]);
        compare_field("illegal", idx, 64'(commit_illegal_o), vec_mem[base+7]);
        // rd and data only mean something on a write
        if (vec_mem[base+3][0]) begin
            compare_field("rd", idx, 64'(commit_rd_o), vec_mem[base+2]);
            compare_field("data", idx, commit_data_o, vec_mem[base+4]);
        end
        // Target only for taken branches and jumps
        if (vec_mem[base+5][0]) begin
            compare_field("target", idx, commit_target_o, vec_mem[base+6]);
        end
    endtask

    // Walks the vectors, holds valid until each transfer
    task automatic drive_vectors();
        int   waited;
        int   base;
        logic gap;
        for (int i = 0; i < NUM_VEC; i++) begin
            base = 8 * i;
            draw_bit(gap);
            if (gap) begin
                instr_valid_i = 1'b0;
                @(posedge clk_i);
                #2;
            end
            instr_valid_i = 1'b1;
            instr_i       = vec_mem[base][31:0];
            pc_i          = vec_mem[base+1];
            waited        = 0;
            // Ready sampled mid cycle, transfer on the next edge
            @(negedge clk_i);
            while (!instr_ready_o && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clk_i);
            end
            if (!instr_ready_o) begin
                timeouts++;
                $display("Timeout: instruction %0d was never accepted", i);
                instr_valid_i = 1'b0;
                return;
            end
            accepted_q.push_back(i);
            @(posedge clk_i);
            #2;
        end
        instr_valid_i = 1'b0;
    endtask

    // Checks commits in order and drives random back-pressure
    task automatic watch_commits();
        int   checked;
        int   idle;
        int   idx;
        logic b0;
        logic b1;
        checked = 0;
        idle    = 0;
        while (checked < NUM_VEC && idle < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (commit_valid_o && commit_ready_i) begin
                assert (accepted_q.size() > 0) else begin
                    errors++;
                    $display("[FAIL] %0t: commit of pc %h with no instruction outstanding",
                             $time, commit_pc_o);
                end
                if (accepted_q.size() > 0) begin
                    idx = accepted_q.pop_front();
                    check_commit(idx);
                end
                checked++;
                idle = 0;
            end else begin
                idle++;
            end
            // Ready high three cycles in four on average
            draw_bit(b0);
            draw_bit(b1);
            @(posedge clk_i);
            #2;
            commit_ready_i = b0 | b1;
        end
        if (checked < NUM_VEC) begin
            timeouts++;
            $display("Timeout: only %0d of %0d commits arrived", checked, NUM_VEC);
        end
        // Nothing may commit after the last vector
        commit_ready_i = 1'b1;
        repeat (20) begin
            @(negedge clk_i);
            assert (!commit_valid_o) else begin
                errors++;
                $display("[FAIL] %0t: extra commit of pc %h", $time, commit_pc_o);
            end
        end
    endtask

    initial begin
        lfsr_q         = LFSR_SEED;
        errors         = 0;
        timeouts       = 0;
        vectors_ok     = 1'b1;
        rst_n_i        = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        pc_i           = '0;
        commit_ready_i = 1'b0;
        // Fill first so that a short file is caught
        for (int n = 0; n < NUM_VEC * 8; n++) begin
            vec_mem[n] = {32'hDEAD_BEEF ^ 32'(n), 32'(n)};
        end
        $readmemh("test/exec_slice_vectors.txt", vec_mem);
        for (int i = 0; i < NUM_VEC; i++) begin
            if (vec_mem[8*i+3] > 64'd1 || vec_mem[8*i+5] > 64'd1 || vec_mem[8*i+7] > 64'd1) begin
                vectors_ok = 1'b0;
            end
        end
        assert (vectors_ok) else begin
            errors++;
            $display("Vector file is missing, short or malformed");
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        if (vectors_ok) begin
            fork
                drive_vectors();
                watch_commits();
            join
        end
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
